/* Bender.yml */
package:
  name: control_request

sources:
  - hw/control_arbiter_pkg.sv
  - hw/control_fifo_if.sv
  - hw/control_fifo.sv
  - hw/round_robin_bus_arbiter.sv
  - hw/arbiter_n_to_1_request_control.sv
  - hw/control_request_top.sv
  - target: test
    files:
      - tb/tb_control_request_top.sv

/* hw/arbiter_n_to_1_request_control.sv */
`timescale 1ns/1ps

module arbiter_n_to_1_request_control #(
  parameter int NUM_REQUESTOR   = 4,
  parameter int OUT_FIFO_DEPTH  = 16,
  parameter int OUT_PROG_THRESH = 8,
  parameter int IN_FIFO_DEPTH   = 16,
  parameter int IN_PROG_THRESH  = 12
) (
  input  logic                                       ap_clk,
  input  logic                                       areset_control,
  input  control_arbiter_pkg::ControlPacket          request_in [NUM_REQUESTOR-1:0],
  input  logic                                       pop_in,
  output control_arbiter_pkg::FIFOStateSignalsOutput fifo_status_out,
  output logic [NUM_REQUESTOR-1:0]                   grant_out,
  output control_arbiter_pkg::ControlPacket          request_out,
  output logic                                       fifo_setup
);
  import control_arbiter_pkg::*;

  // ------------------------------
  // Input registers
  // ------------------------------
  logic [NUM_REQUESTOR-1:0] in_valid_q;
  ControlPacketPayload      in_payload_q [NUM_REQUESTOR-1:0];

  // Staging side status, one bit per requestor
  logic [NUM_REQUESTOR-1:0] stage_prog_full;
  logic [NUM_REQUESTOR-1:0] stage_busy;

  // Arbiter hookup
  logic [NUM_REQUESTOR-1:0] arbiter_req;
  logic [NUM_REQUESTOR-1:0] arbiter_grant;
  ControlPacket             arbiter_bus_in [NUM_REQUESTOR-1:0];
  ControlPacket             arbiter_bus_out;

  // Output FIFO push register and consumer pop register
  logic                push_valid_q;
  ControlPacketPayload push_payload_q;
  logic                pop_q;

  // Output register
  logic                out_valid_q;
  ControlPacketPayload out_payload_q;

  control_fifo_if out_if ();

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      in_valid_q <= '0;
      pop_q      <= 1'b0;
    end else begin
      for (int i = 0; i < NUM_REQUESTOR; i++) begin
        in_valid_q[i] <= request_in[i].valid;
      end
      pop_q <= pop_in;
    end
  end

  always_ff @(posedge ap_clk) begin
    for (int i = 0; i < NUM_REQUESTOR; i++) begin
      in_payload_q[i] <= request_in[i].payload;
    end
  end

  // ------------------------------
  // Staging FIFOs
  // ------------------------------
  for (genvar i = 0; i < NUM_REQUESTOR; i++) begin : gen_stage
    control_fifo_if stage_if ();

    assign stage_if.wr_en = in_valid_q[i];
    assign stage_if.din   = in_payload_q[i];
    // Granted index pops its own FIFO
    assign stage_if.rd_en = arbiter_grant[i] & ~stage_if.empty;

    assign arbiter_req[i]     = ~stage_if.empty;
    assign arbiter_bus_in[i]  = '{valid: stage_if.valid, payload: stage_if.dout};
    assign stage_prog_full[i] = stage_if.prog_full;
    assign stage_busy[i]      = stage_if.rst_busy;

    control_fifo #(
      .DEPTH      (IN_FIFO_DEPTH),
      .PROG_THRESH(IN_PROG_THRESH)
    ) u_stage_fifo (
      .ap_clk        (ap_clk),
      .areset_control(areset_control),
      .fifo          (stage_if.fifo)
    );
  end

  round_robin_bus_arbiter #(
    .NUM_REQUESTOR(NUM_REQUESTOR)
  ) u_arbiter (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .arbiter_req    (arbiter_req),
    .arbiter_bus_in (arbiter_bus_in),
    .arbiter_grant  (arbiter_grant),
    .arbiter_bus_out(arbiter_bus_out)
  );

  // ------------------------------
  // Output FIFO
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      push_valid_q <= 1'b0;
      out_valid_q  <= 1'b0;
    end else begin
      push_valid_q <= arbiter_bus_out.valid;
      out_valid_q  <= out_if.valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    push_payload_q <= arbiter_bus_out.payload;
    out_payload_q  <= out_if.dout;
  end

  assign out_if.wr_en = push_valid_q;
  assign out_if.din   = push_payload_q;
  // Registered consumer pop, only when something is there
  assign out_if.rd_en = pop_q & ~out_if.empty;

  control_fifo #(
    .DEPTH      (OUT_FIFO_DEPTH),
    .PROG_THRESH(OUT_PROG_THRESH)
  ) u_out_fifo (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .fifo          (out_if.fifo)
  );

  assign request_out = '{valid: out_valid_q, payload: out_payload_q};

  // ------------------------------
  // Grants, status, setup flag
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      grant_out                 <= '0;
      fifo_setup                <= 1'b1;
      fifo_status_out.prog_full <= 1'b0;
      fifo_status_out.empty     <= 1'b1;
    end else begin
      for (int i = 0; i < NUM_REQUESTOR; i++) begin
        // Held low also while any FIFO on the path is still resetting
        grant_out[i] <= ~(stage_prog_full[i] | out_if.prog_full |
                          stage_busy[i] | out_if.rst_busy);
      end
      fifo_setup                <= (|stage_busy) | out_if.rst_busy;
      fifo_status_out.prog_full <= out_if.prog_full;
      fifo_status_out.empty     <= out_if.empty;
    end
  end

endmodule : arbiter_n_to_1_request_control

/* hw/control_arbiter_pkg.sv */
package control_arbiter_pkg;

  // ------------------------------
  // Control packet layout
  // ------------------------------

  // Payload carried through every FIFO
  typedef struct packed {
    // Compute-unit id of the sender
    logic [7:0]  id_cu;
    // Command code
    logic [3:0]  opcode;
    // Vertex or edge word
    logic [31:0] data;
  } ControlPacketPayload;

  // Payload plus its strobe
  typedef struct packed {
    logic                valid;
    ControlPacketPayload payload;
  } ControlPacket;

  // ------------------------------
  // FIFO status toward the consumer
  // ------------------------------
  typedef struct packed {
    logic prog_full;
    logic empty;
  } FIFOStateSignalsOutput;

  // Flattened payload width for plain ports
  localparam int PAYLOAD_W = $bits(ControlPacketPayload);

  // Cycles a FIFO stays busy once reset is released
  localparam int RESET_BUSY_CYCLES = 4;

endpackage : control_arbiter_pkg

/* hw/control_fifo.sv */
`timescale 1ns/1ps

module control_fifo #(
  parameter int DEPTH       = 16,
  parameter int PROG_THRESH = 12
) (
  input logic         ap_clk,
  input logic         areset_control,
  control_fifo_if.fifo fifo
);
  import control_arbiter_pkg::*;

  localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W  = $clog2(DEPTH + 1);
  localparam int BUSY_W = $clog2(RESET_BUSY_CYCLES + 1);

  localparam logic [CNT_W-1:0]  FULL_LEVEL = CNT_W'(DEPTH);
  localparam logic [CNT_W-1:0]  PROG_LEVEL = CNT_W'(PROG_THRESH);
  localparam logic [PTR_W-1:0]  LAST_SLOT  = PTR_W'(DEPTH - 1);
  localparam logic [BUSY_W-1:0] BUSY_LOAD  = BUSY_W'(RESET_BUSY_CYCLES);

  // ------------------------------
  // Storage and pointers
  // ------------------------------
  ControlPacketPayload mem [DEPTH];

  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic [BUSY_W-1:0] busy_cnt;

  logic push_ok;
  logic pop_ok;

  // Wrap at the last slot, depth need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == LAST_SLOT) ? '0 : ptr + 1'b1;
  endfunction

  // Status straight from the occupancy
  assign fifo.empty     = (count == '0);
  assign fifo.full      = (count == FULL_LEVEL);
  assign fifo.prog_full = (count >= PROG_LEVEL);
  assign fifo.rst_busy  = (busy_cnt != '0);

  // Nothing moves while busy
  assign push_ok = fifo.wr_en & ~fifo.full & ~fifo.rst_busy;
  assign pop_ok  = fifo.rd_en & ~fifo.empty & ~fifo.rst_busy;

  // ------------------------------
  // Pointers, occupancy, busy timer
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      busy_cnt   <= BUSY_LOAD;
      fifo.valid <= 1'b0;
    end else begin
      if (push_ok) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop_ok) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // Simultaneous push and pop leaves the count alone
      if (push_ok && !pop_ok) begin
        count <= count + 1'b1;
      end else if (pop_ok && !push_ok) begin
        count <= count - 1'b1;
      end
      // Count down after reset release
      if (busy_cnt != '0) begin
        busy_cnt <= busy_cnt - 1'b1;
      end
      // One-cycle pulse after each pop
      fifo.valid <= pop_ok;
    end
  end

  // Data path
  always_ff @(posedge ap_clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= fifo.din;
    end
    // Head word held until the next pop
    if (pop_ok) begin
      fifo.dout <= mem[rd_ptr];
    end
  end

endmodule : control_fifo

/* hw/control_fifo_if.sv */
`timescale 1ns/1ps

interface control_fifo_if;
  import control_arbiter_pkg::*;

  // Push side
  logic                wr_en;
  ControlPacketPayload din;
  // Pop side
  logic                rd_en;
  ControlPacketPayload dout;
  logic                valid;
  // Status
  logic                empty;
  logic                full;
  logic                prog_full;
  logic                rst_busy;

  // Block that feeds and drains the FIFO
  modport producer (
    output wr_en, din, rd_en,
    input  dout, valid, empty, full, prog_full, rst_busy
  );

  // The FIFO itself
  modport fifo (
    input  wr_en, din, rd_en,
    output dout, valid, empty, full, prog_full, rst_busy
  );

endinterface : control_fifo_if

/* hw/control_request_top.sv */
`timescale 1ns/1ps

module control_request_top #(
  parameter int NUM_REQUESTOR   = 4,
  parameter int OUT_FIFO_DEPTH  = 16,
  parameter int OUT_PROG_THRESH = 8,
  parameter int IN_FIFO_DEPTH   = 16,
  parameter int IN_PROG_THRESH  = 12
) (
  input  logic                                                  ap_clk,
  input  logic                                                  areset_control,
  input  logic [NUM_REQUESTOR-1:0]                              request_in_valid,
  input  logic [NUM_REQUESTOR*control_arbiter_pkg::PAYLOAD_W-1:0] request_in_payload,
  input  logic                                                  pop_in,
  output logic [NUM_REQUESTOR-1:0]                              grant_out,
  output logic                                                  request_out_valid,
  output logic [control_arbiter_pkg::PAYLOAD_W-1:0]             request_out_payload,
  output logic                                                  status_empty,
  output logic                                                  status_prog_full,
  output logic                                                  fifo_setup
);
  import control_arbiter_pkg::*;

  ControlPacket          request_in [NUM_REQUESTOR-1:0];
  ControlPacket          request_out;
  FIFOStateSignalsOutput fifo_status;

  // ------------------------------
  // Flat ports to packet arrays
  // ------------------------------

  // Requestor i owns payload slice i
  always_comb begin
    for (int i = 0; i < NUM_REQUESTOR; i++) begin
      request_in[i].valid   = request_in_valid[i];
      request_in[i].payload = request_in_payload[i*PAYLOAD_W +: PAYLOAD_W];
    end
  end

  arbiter_n_to_1_request_control #(
    .NUM_REQUESTOR  (NUM_REQUESTOR),
    .OUT_FIFO_DEPTH (OUT_FIFO_DEPTH),
    .OUT_PROG_THRESH(OUT_PROG_THRESH),
    .IN_FIFO_DEPTH  (IN_FIFO_DEPTH),
    .IN_PROG_THRESH (IN_PROG_THRESH)
  ) u_request_control (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .request_in     (request_in),
    .pop_in         (pop_in),
    .fifo_status_out(fifo_status),
    .grant_out      (grant_out),
    .request_out    (request_out),
    .fifo_setup     (fifo_setup)
  );

  // Back to plain outputs
  assign request_out_valid   = request_out.valid;
  assign request_out_payload = request_out.payload;
  assign status_empty        = fifo_status.empty;
  assign status_prog_full    = fifo_status.prog_full;

endmodule : control_request_top

/* hw/round_robin_bus_arbiter.sv */
`timescale 1ns/1ps

module round_robin_bus_arbiter #(
  parameter int NUM_REQUESTOR = 4
) (
  input  logic                              ap_clk,
  input  logic                              areset_control,
  input  logic [NUM_REQUESTOR-1:0]          arbiter_req,
  input  control_arbiter_pkg::ControlPacket arbiter_bus_in [NUM_REQUESTOR-1:0],
  output logic [NUM_REQUESTOR-1:0]          arbiter_grant,
  output control_arbiter_pkg::ControlPacket arbiter_bus_out
);
  import control_arbiter_pkg::*;

  localparam int IDX_W = (NUM_REQUESTOR > 1) ? $clog2(NUM_REQUESTOR) : 1;

  // Index of the most recent grant
  logic [IDX_W-1:0] last_idx;
  logic [IDX_W-1:0] sel_idx;
  // A popped word is still on its way
  logic             wait_valid;
  logic             grant_ok;
  logic             any_grant;

  // Bus mux result
  logic                any_valid;
  ControlPacketPayload mux_payload;

  // ------------------------------
  // Grant selection
  // ------------------------------

  // Free to grant once the previous pop has shown up
  assign grant_ok  = ~wait_valid | any_valid;
  assign any_grant = |arbiter_grant;

  always_comb begin
    int  idx;
    logic found;
    arbiter_grant = '0;
    sel_idx       = last_idx;
    found         = 1'b0;
    // Search starts one past the last winner
    for (int k = 1; k <= NUM_REQUESTOR; k++) begin
      idx = (int'(last_idx) + k) % NUM_REQUESTOR;
      if (!found && grant_ok && arbiter_req[idx]) begin
        arbiter_grant[idx] = 1'b1;
        sel_idx            = IDX_W'(idx);
        found              = 1'b1;
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      // First search begins at index 0
      last_idx   <= IDX_W'(NUM_REQUESTOR - 1);
      wait_valid <= 1'b0;
    end else begin
      if (any_grant) begin
        last_idx   <= sel_idx;
        wait_valid <= 1'b1;
      end else if (any_valid) begin
        wait_valid <= 1'b0;
      end
    end
  end

  // ------------------------------
  // Output bus
  // ------------------------------

  // At most one source pulses valid per cycle
  always_comb begin
    any_valid   = 1'b0;
    mux_payload = '0;
    for (int i = 0; i < NUM_REQUESTOR; i++) begin
      if (arbiter_bus_in[i].valid) begin
        any_valid   = 1'b1;
        mux_payload = arbiter_bus_in[i].payload;
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      arbiter_bus_out.valid <= 1'b0;
    end else begin
      arbiter_bus_out.valid <= any_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    arbiter_bus_out.payload <= mux_payload;
  end

endmodule : round_robin_bus_arbiter

/* list.f */
hw/control_arbiter_pkg.sv
hw/control_fifo_if.sv
hw/control_fifo.sv
hw/round_robin_bus_arbiter.sv
hw/arbiter_n_to_1_request_control.sv
hw/control_request_top.sv
tb/tb_control_request_top.sv

/* tb/control_request_vectors.txt */
# test src id_cu opcode data pop_en (test, src, pop_en decimal; id_cu, opcode, data hex)
# Test 2 single, 3 concurrent, 4 round-robin preload, 5 back-pressure
2 0 10 1 20000001 1
2 1 11 2 20000102 1
2 2 12 3 20000203 1
2 3 13 4 20000304 1
3 0 10 5 30000001 1
3 1 11 6 30000101 1
3 2 12 7 30000201 1
3 3 13 8 30000301 1
3 0 10 9 30000002 1
3 1 11 a 30000102 1
3 2 12 b 30000202 1
3 3 13 c 30000302 1
4 0 10 1 40000001 0
4 1 11 1 40000101 0
4 2 12 1 40000201 0
4 3 13 1 40000301 0
4 0 10 2 40000002 0
4 1 11 2 40000102 0
4 2 12 2 40000202 0
4 3 13 2 40000302 0
5 0 10 d 5a000001 0
5 1 11 d 5a000101 0
5 2 12 d 5a000201 0
5 3 13 d 5a000301 0
5 0 10 e 5a000002 0
5 1 11 e 5a000102 0
5 2 12 e 5a000202 0
5 3 13 e 5a000302 0

/* tb/tb_control_request_top.sv */
`timescale 1ns/1ps

module tb_control_request_top;
  import control_arbiter_pkg::*;

  localparam int N       = 4;
  localparam int PW      = control_arbiter_pkg::PAYLOAD_W;
  localparam int MAX_VEC = 64;
  localparam int TIMEOUT = 500;
  // Level conditions for wait_until
  localparam int LVL_SETUP = 0;
  localparam int LVL_FULL  = 1;
  localparam int LVL_EMPTY = 2;

  logic            ap_clk;
  logic            areset_control;
  logic [N-1:0]    request_in_valid;
  logic [N*PW-1:0] request_in_payload;
  logic            pop_in;
  logic [N-1:0]    grant_out;
  logic            request_out_valid;
  logic [PW-1:0]   request_out_payload;
  logic            status_empty;
  logic            status_prog_full;
  logic            fifo_setup;

  // Vectors as read from file
  int            vec_test [MAX_VEC];
  int            vec_src  [MAX_VEC];
  int            vec_pop  [MAX_VEC];
  logic [PW-1:0] vec_pay  [MAX_VEC];
  int            nvec;

  // Expected packets, one ordered list per source
  logic [PW-1:0] exp_pay [N][MAX_VEC];
  int            exp_head [N];
  int            exp_tail [N];
  logic [PW-1:0] rx_q [$];

  int errors;
  int n_pass;
  int n_fail;

  control_request_top #(.NUM_REQUESTOR(N)) u_control_request_top (
    .ap_clk             (ap_clk),
    .areset_control     (areset_control),
    .request_in_valid   (request_in_valid),
    .request_in_payload (request_in_payload),
    .pop_in             (pop_in),
    .grant_out          (grant_out),
    .request_out_valid  (request_out_valid),
    .request_out_payload(request_out_payload),
    .status_empty       (status_empty),
    .status_prog_full   (status_prog_full),
    .fifo_setup         (fifo_setup)
  );

  initial begin
    ap_clk = 1'b0;
    forever #20 ap_clk = ~ap_clk;
  end

  // Output monitor, sampled mid-cycle
  always @(negedge ap_clk) begin
    if (request_out_valid === 1'b1) begin
      rx_q.push_back(request_out_payload);
    end
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic load_vectors();
    int          fd;
    int          got;
    string       line;
    int          tid;
    int          src;
    int          pop;
    logic [7:0]  idc;
    logic [3:0]  opc;
    logic [31:0] dat;
    nvec = 0;
    fd = $fopen("tb/control_request_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open tb/control_request_vectors.txt");
      errors++;
      return;
    end
    while (!$feof(fd) && nvec < MAX_VEC) begin
      got = $fgets(line, fd);
      // Comment lines fail the scan and are skipped
      if (got > 0 && $sscanf(line, "%d %d %h %h %h %d", tid, src, idc, opc, dat, pop) == 6) begin
        if (src >= 0 && src < N) begin
          vec_test[nvec] = tid;
          vec_src[nvec]  = src;
          vec_pop[nvec]  = pop;
          vec_pay[nvec]  = {idc, opc, dat};
          nvec++;
        end
      end
    end
    $fclose(fd);
  endtask

  function automatic int outstanding();
    int total;
    total = 0;
    for (int s = 0; s < N; s++) begin
      total += exp_tail[s] - exp_head[s];
    end
    return total;
  endfunction

  task automatic clear_expected();
    for (int s = 0; s < N; s++) begin
      exp_head[s] = 0;
      exp_tail[s] = 0;
    end
  endtask

  function automatic bit level_reached(input int kind);
    case (kind)
      LVL_SETUP: return fifo_setup === 1'b0;
      LVL_FULL:  return status_prog_full === 1'b1 && grant_out === '0;
      default:   return status_empty === 1'b1;
    endcase
  endfunction

  task automatic wait_until(input int kind, input int limit, input string what);
    int cnt;
    cnt = 0;
    while (!level_reached(kind) && cnt < limit) begin
      @(negedge ap_clk);
      cnt++;
    end
    if (!level_reached(kind)) begin
      $display("Timeout waiting for %s", what);
      errors++;
    end
  endtask

  // Each source walks its own vectors, sending only under grant
  task automatic send_range(input int lo, input int hi);
    int   cursor [N];
    int   cnt;
    logic busy;
    for (int s = 0; s < N; s++) begin
      cursor[s] = lo;
    end
    cnt  = 0;
    busy = 1'b1;
    while (busy && cnt < TIMEOUT) begin
      @(negedge ap_clk);
      request_in_valid = '0;
      busy             = 1'b0;
      for (int s = 0; s < N; s++) begin
        while (cursor[s] <= hi && vec_src[cursor[s]] != s) begin
          cursor[s]++;
        end
        if (cursor[s] <= hi) begin
          busy = 1'b1;
          if (grant_out[s] === 1'b1) begin
            request_in_valid[s]            = 1'b1;
            request_in_payload[s*PW +: PW] = vec_pay[cursor[s]];
            exp_pay[s][exp_tail[s]]        = vec_pay[cursor[s]];
            exp_tail[s]++;
            cursor[s]++;
          end
        end
      end
      cnt++;
    end
    if (busy) begin
      $display("Timeout: a source never got its grant back");
      errors++;
      @(negedge ap_clk);
      request_in_valid = '0;
    end
  endtask

  // Drain with a random pop duty, match each output to a source head
  task automatic collect(input bit check_rr);
    int            cnt;
    int            prev;
    int            src;
    int            duty;
    bit            all_held;
    logic [PW-1:0] got;
    cnt  = 0;
    prev = -1;
    duty = $urandom_range(3, 1);
    while (outstanding() > 0 && cnt < TIMEOUT) begin
      @(negedge ap_clk);
      pop_in = ($urandom_range(3) < duty);
      @(posedge ap_clk);
      while (rx_q.size() > 0) begin
        got      = rx_q.pop_front();
        src      = -1;
        all_held = 1'b1;
        for (int s = 0; s < N; s++) begin
          if (exp_head[s] == exp_tail[s]) begin
            all_held = 1'b0;
          end else if (src < 0 && exp_pay[s][exp_head[s]] == got) begin
            src = s;
          end
        end
        if (src < 0) begin
          $display("Mismatch at %0t: payload %h is no source's next packet", $time, got);
          errors++;
        end else begin
          // Cyclic order only while every source still has packets
          if (check_rr && all_held && prev >= 0 && src != (prev + 1) % N) begin
            $display("Mismatch at %0t: source %0d came after source %0d", $time, src, prev);
            errors++;
          end
          exp_head[src]++;
          prev = src;
        end
      end
      cnt++;
    end
    if (outstanding() > 0) begin
      $display("Timeout: %0d packets never reached the output", outstanding());
      errors++;
    end
    clear_expected();
  endtask

  // Random idle gap, nothing may arrive during it
  task automatic idle_gap();
    @(negedge ap_clk);
    pop_in = 1'b1;
    repeat ($urandom_range(5, 2)) @(negedge ap_clk);
    @(posedge ap_clk);
    if (rx_q.size() != 0) begin
      $display("Mismatch at %0t: %0d unexpected output packets", $time, rx_q.size());
      errors++;
      rx_q.delete();
    end
  endtask

  task automatic find_range(input int tid, output int lo, output int hi);
    lo = -1;
    hi = -1;
    for (int i = 0; i < nvec; i++) begin
      if (vec_test[i] == tid) begin
        if (lo < 0) begin
          lo = i;
        end
        hi = i;
      end
    end
    if (lo < 0) begin
      $display("No vectors found for test %0d", tid);
      errors++;
    end
  endtask

  // Concurrent burst, with an optional preload under pop low
  task automatic run_burst(input int tid, input bit check_rr);
    int lo;
    int hi;
    find_range(tid, lo, hi);
    if (lo < 0) begin
      return;
    end
    @(negedge ap_clk);
    pop_in = (vec_pop[lo] != 0);
    send_range(lo, hi);
    if (vec_pop[lo] == 0) begin
      wait_until(LVL_FULL, TIMEOUT, "prog_full with all grants low");
    end
    collect(check_rr);
    wait_until(LVL_EMPTY, TIMEOUT, "status_empty to return high");
  endtask

  task automatic report_test(input int id, input string name, input int err_before);
    if (errors == err_before) begin
      $display("Test %0d %s: ok", id, name);
      n_pass++;
    end else begin
      $display("Test %0d %s: %0d errors", id, name, errors - err_before);
      n_fail++;
    end
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    int lo;
    int hi;
    int e0;
    void'($urandom(32'he6d6_a27b));
    areset_control     = 1'b1;
    request_in_valid   = '0;
    request_in_payload = '0;
    pop_in             = 1'b0;
    errors             = 0;
    n_pass             = 0;
    n_fail             = 0;
    clear_expected();
    load_vectors();
    // Four rising edges under reset, release mid-cycle
    repeat (4) @(posedge ap_clk);
    @(negedge ap_clk);
    areset_control = 1'b0;

    // Status right after reset release
    e0 = errors;
    @(negedge ap_clk);
    if (request_out_valid !== 1'b0 || status_empty !== 1'b1 ||
        status_prog_full !== 1'b0 || fifo_setup !== 1'b1) begin
      $display("Mismatch at %0t: valid=%b empty=%b prog_full=%b setup=%b after reset",
               $time, request_out_valid, status_empty, status_prog_full, fifo_setup);
      errors++;
    end
    wait_until(LVL_SETUP, RESET_BUSY_CYCLES + 8, "fifo_setup to fall");
    report_test(1, "reset and setup", e0);

    if (nvec > 0) begin
      // One packet per source, each drained before the next
      e0 = errors;
      find_range(2, lo, hi);
      for (int i = lo; i <= hi && lo >= 0; i++) begin
        send_range(i, i);
        collect(1'b0);
      end
      idle_gap();
      report_test(2, "single packet", e0);

      e0 = errors;
      run_burst(3, 1'b0);
      idle_gap();
      report_test(3, "concurrent sources", e0);

      e0 = errors;
      run_burst(4, 1'b1);
      idle_gap();
      report_test(4, "round-robin fairness", e0);

      e0 = errors;
      run_burst(5, 1'b0);
      idle_gap();
      report_test(5, "back-pressure", e0);
    end else begin
      $display("No usable lines in tb/control_request_vectors.txt");
      errors++;
    end

    $display("Tests ok: %0d, tests with errors: %0d, total errors: %0d", n_pass, n_fail, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule : tb_control_request_top
